//--- rtl/tcb_macros.svh
//////////////////////////////
// bus widths, response delay and credit depth for the TCB subsystem
// TCB_DLY of 1 is what the subordinates implement
// TCB_CRD must be a power of two, at least 2
//////////////////////////////
`ifndef TCB_MACROS_SVH
`define TCB_MACROS_SVH

// address width, bit 15 selects the subordinate
`define TCB_AW 16
// data width
`define TCB_DW 32
// byte enables, one per data byte
`define TCB_BW 4

// response delay after a transfer, in cycles
`define TCB_DLY 1

// command FIFO depth and initial response credits
`define TCB_CRD 4

`endif

//--- rtl/tcb_pkg.sv
//////////////////////////////
// TCB types shared by manager, decoder and subordinates
// widths come from the macro header
//////////////////////////////
`default_nettype none

`include "tcb_macros.svh"

package tcb_pkg;

  // external command opcode
  typedef enum logic [0:0] {
    OP_RD = 1'b0,
    OP_WR = 1'b1
  } tcb_op_e;

  // bus request, 53 bits
  typedef struct packed {
    logic              wen;
    logic [`TCB_AW-1:0] adr;
    logic [`TCB_BW-1:0] ben;
    logic [`TCB_DW-1:0] wdt;
  } tcb_req_t;

  // bus response, 33 bits
  typedef struct packed {
    logic [`TCB_DW-1:0] rdt;
    logic              err;
  } tcb_rsp_t;

  // command from outside, same layout as the request
  typedef struct packed {
    tcb_op_e           op;
    logic [`TCB_AW-1:0] adr;
    logic [`TCB_BW-1:0] ben;
    logic [`TCB_DW-1:0] wdt;
  } tcb_cmd_t;

endpackage

`default_nettype wire

//--- rtl/tcb_man.sv
//////////////////////////////
// TCB manager, credit based on both external channels
// the sender must hold a credit for each cmd_vld cycle
// no bus back-pressure, every vld cycle is a transfer
// responses leave TCB_DLY+1 cycles after the transfer
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "tcb_macros.svh"

module tcb_man (
  input  logic              bus,
  input  logic              reset,
  // command channel
  input  logic              cmd_vld,
  input  tcb_pkg::tcb_cmd_t cmd,
  output logic              cmd_crd,
  // response channel
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp,
  input  logic              rsp_crd,
  // bus side
  output logic              bus_vld,
  output tcb_pkg::tcb_req_t bus_req,
  input  tcb_pkg::tcb_rsp_t bus_rsp
);

  // pointer and counter widths
  localparam int unsigned PW = $clog2(`TCB_CRD);
  localparam int unsigned CW = $clog2(`TCB_CRD + 1);

  tcb_pkg::tcb_cmd_t   fifo_mem [`TCB_CRD];
  tcb_pkg::tcb_cmd_t   head;
  logic [PW-1:0]       wr_ptr;
  logic [PW-1:0]       rd_ptr;
  logic [CW-1:0]       fifo_cnt;
  logic [CW-1:0]       crd_cnt;
  logic                issue;
  // transfer flags, bit TCB_DLY-1 marks a valid bus_rsp
  logic [`TCB_DLY-1:0] trn_sr;

  //////////////////////////////
  // command FIFO
  //////////////////////////////

  // sender credits keep the FIFO from overflowing
  always_ff @(posedge bus) begin
    if (cmd_vld) begin
      fifo_mem[wr_ptr] <= cmd;
    end
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (cmd_vld) begin
        wr_ptr <= wr_ptr + PW'(1);
      end
      if (issue) begin
        rd_ptr <= rd_ptr + PW'(1);
      end
      fifo_cnt <= fifo_cnt + CW'(cmd_vld) - CW'(issue);
    end
  end

  assign head = fifo_mem[rd_ptr];

  //////////////////////////////
  // response credits and issue
  //////////////////////////////

  // issue only with a reserved response slot
  assign issue = (fifo_cnt != '0) && (crd_cnt != '0);

  // spent on issue, returned by the consumer
  always_ff @(posedge bus) begin
    if (reset) begin
      crd_cnt <= CW'(`TCB_CRD);
    end else begin
      crd_cnt <= crd_cnt + CW'(rsp_crd) - CW'(issue);
    end
  end

  // registered request driver
  always_ff @(posedge bus) begin
    if (reset) begin
      bus_vld <= 1'b0;
    end else begin
      bus_vld <= issue;
    end
  end

  // opcode maps onto write enable
  always_ff @(posedge bus) begin
    if (issue) begin
      bus_req.wen <= (head.op == tcb_pkg::OP_WR);
      bus_req.adr <= head.adr;
      bus_req.ben <= head.ben;
      bus_req.wdt <= head.wdt;
    end
  end

  // each transfer frees exactly one FIFO slot
  assign cmd_crd = bus_vld;

  //////////////////////////////
  // response delay line
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      trn_sr  <= '0;
      rsp_vld <= 1'b0;
    end else begin
      trn_sr[0] <= bus_vld;
      for (int i = 1; i < `TCB_DLY; i++) begin
        trn_sr[i] <= trn_sr[i-1];
      end
      rsp_vld <= trn_sr[`TCB_DLY-1];
    end
  end

  // capture response payload
  always_ff @(posedge bus) begin
    if (trn_sr[`TCB_DLY-1]) begin
      rsp <= bus_rsp;
    end
  end

endmodule

`default_nettype wire

//--- rtl/tcb_dec.sv
//////////////////////////////
// TCB one-to-two decoder
// address MSB low selects memory, high selects registers
// requests pass combinationally, select is delayed TCB_DLY
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "tcb_macros.svh"

module tcb_dec (
  input  logic              bus,
  input  logic              reset,
  // manager side
  input  logic              man_vld,
  input  tcb_pkg::tcb_req_t man_req,
  output tcb_pkg::tcb_rsp_t man_rsp,
  // memory subordinate
  output logic              mem_vld,
  output tcb_pkg::tcb_req_t mem_req,
  input  tcb_pkg::tcb_rsp_t mem_rsp,
  // register subordinate
  output logic              reg_vld,
  output tcb_pkg::tcb_req_t reg_req,
  input  tcb_pkg::tcb_rsp_t reg_rsp
);

  // select bit position
  localparam int unsigned SB = `TCB_AW - 1;

  logic                sel;
  // select history, one stage per cycle of delay
  logic [`TCB_DLY-1:0] sel_sr;

  //////////////////////////////
  // request routing
  //////////////////////////////

  assign sel = man_req.adr[SB];

  // only the selected side sees vld
  assign mem_vld = man_vld & ~sel;
  assign reg_vld = man_vld & sel;

  // payload broadcast to both
  assign mem_req = man_req;
  assign reg_req = man_req;

  //////////////////////////////
  // response steering
  //////////////////////////////

  // idle cycles fall back to memory
  always_ff @(posedge bus) begin
    if (reset) begin
      sel_sr <= '0;
    end else begin
      sel_sr[0] <= man_vld & sel;
      for (int i = 1; i < `TCB_DLY; i++) begin
        sel_sr[i] <= sel_sr[i-1];
      end
    end
  end

  // each response comes from the side that took its transfer
  assign man_rsp = sel_sr[`TCB_DLY-1] ? reg_rsp : mem_rsp;

endmodule

`default_nettype wire

//--- rtl/tcb_mem.sv
//////////////////////////////
// TCB memory, 256 words with byte enables
// response registered one cycle after the transfer
// adr bits 14:10 nonzero give err, memory unchanged
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "tcb_macros.svh"

module tcb_mem (
  input  logic              bus,
  input  logic              reset,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output tcb_pkg::tcb_rsp_t rsp
);

  localparam int unsigned DEPTH = 256;

  logic [`TCB_DW-1:0] mem [DEPTH];
  // word index
  logic [7:0]         idx;
  logic               err;

  assign idx = req.adr[9:2];
  // unmapped part of the window
  assign err = (req.adr[14:10] != '0);

  // byte-enabled write
  always_ff @(posedge bus) begin
    if (vld && req.wen && !err) begin
      for (int b = 0; b < `TCB_BW; b++) begin
        if (req.ben[b]) begin
          mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  // read data only for good reads, zero otherwise
  always_ff @(posedge bus) begin
    if (reset) begin
      rsp <= '0;
    end else if (vld) begin
      rsp.err <= err;
      rsp.rdt <= (req.wen || err) ? '0 : mem[idx];
    end
  end

endmodule

`default_nettype wire

//--- rtl/tcb_reg.sv
//////////////////////////////
// TCB register bank, eight words at 0x00 to 0x1c
// other offsets and misaligned addresses give err
// registers clear on reset
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "tcb_macros.svh"

module tcb_reg (
  input  logic              bus,
  input  logic              reset,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output tcb_pkg::tcb_rsp_t rsp
);

  localparam int unsigned NREG = 8;

  logic [`TCB_DW-1:0] regs [NREG];
  // register index
  logic [2:0]         idx;
  logic               err;

  assign idx = req.adr[4:2];
  // beyond 0x1c or not word aligned
  assign err = (req.adr[14:5] != '0) || (req.adr[1:0] != '0);

  always_ff @(posedge bus) begin
    if (reset) begin
      for (int r = 0; r < NREG; r++) begin
        regs[r] <= '0;
      end
      rsp <= '0;
    end else if (vld) begin
      // byte-enabled write, blocked on err
      if (req.wen && !err) begin
        for (int b = 0; b < `TCB_BW; b++) begin
          if (req.ben[b]) begin
            regs[idx][8*b +: 8] <= req.wdt[8*b +: 8];
          end
        end
      end
      rsp.err <= err;
      rsp.rdt <= (req.wen || err) ? '0 : regs[idx];
    end
  end

endmodule

`default_nettype wire

//--- rtl/tcb_sys.sv
//////////////////////////////
// TCB subsystem top, manager and two subordinates
// credit rules of tcb_man apply at the ports
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tcb_sys (
  input  logic              bus,
  input  logic              reset,
  // command channel
  input  logic              cmd_vld,
  input  tcb_pkg::tcb_cmd_t cmd,
  output logic              cmd_crd,
  // response channel
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp,
  input  logic              rsp_crd
);

  // manager to decoder
  logic              man_vld;
  tcb_pkg::tcb_req_t man_req;
  tcb_pkg::tcb_rsp_t man_rsp;
  // decoder to memory
  logic              mem_vld;
  tcb_pkg::tcb_req_t mem_req;
  tcb_pkg::tcb_rsp_t mem_rsp;
  // decoder to registers
  logic              reg_vld;
  tcb_pkg::tcb_req_t reg_req;
  tcb_pkg::tcb_rsp_t reg_rsp;

  tcb_man i_tcb_man (
    .bus     (bus),
    .reset   (reset),
    .cmd_vld (cmd_vld),
    .cmd     (cmd),
    .cmd_crd (cmd_crd),
    .rsp_vld (rsp_vld),
    .rsp     (rsp),
    .rsp_crd (rsp_crd),
    .bus_vld (man_vld),
    .bus_req (man_req),
    .bus_rsp (man_rsp)
  );

  tcb_dec i_tcb_dec (
    .bus     (bus),
    .reset   (reset),
    .man_vld (man_vld),
    .man_req (man_req),
    .man_rsp (man_rsp),
    .mem_vld (mem_vld),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .reg_vld (reg_vld),
    .reg_req (reg_req),
    .reg_rsp (reg_rsp)
  );

  tcb_mem i_tcb_mem (
    .bus   (bus),
    .reset (reset),
    .vld   (mem_vld),
    .req   (mem_req),
    .rsp   (mem_rsp)
  );

  tcb_reg i_tcb_reg (
    .bus   (bus),
    .reset (reset),
    .vld   (reg_vld),
    .req   (reg_req),
    .rsp   (reg_rsp)
  );

endmodule

`default_nettype wire

//--- verif/tcb_sys_props.sv
//////////////////////////////
// checks on tcb_man, bound into every instance
// assumes TCB_DLY response timing and TCB_CRD credits
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "tcb_macros.svh"

module tcb_sys_props (
  input logic bus,
  input logic reset,
  input logic bus_vld,
  input logic rsp_vld,
  input logic rsp_crd,
  input logic cmd_crd
);

  // transfers issued whose response credit is not back yet
  logic [7:0] open_cnt;

  always_ff @(posedge bus) begin
    if (reset) begin
      open_cnt <= '0;
    end else begin
      open_cnt <= open_cnt + 8'(bus_vld) - 8'(rsp_crd);
    end
  end

  // outputs quiet right after reset
  reset_quiet: assert property (@(posedge bus) reset |=> !rsp_vld && !cmd_crd)
    else $error("rsp_vld or cmd_crd high after reset");

  // never more in flight than response credits
  open_limit: assert property (@(posedge bus) disable iff (reset) open_cnt <= `TCB_CRD)
    else $error("more than TCB_CRD transfers in flight");

  // each transfer answered after TCB_DLY+1 cycles
  rsp_follows: assert property (@(posedge bus) disable iff (reset)
    bus_vld |-> ##(`TCB_DLY + 1) rsp_vld)
    else $error("rsp_vld missing after bus transfer");

endmodule

bind tcb_man tcb_sys_props i_tcb_sys_props (
  .bus     (bus),
  .reset   (reset),
  .bus_vld (bus_vld),
  .rsp_vld (rsp_vld),
  .rsp_crd (rsp_crd),
  .cmd_crd (cmd_crd)
);

`default_nettype wire

//--- verif/tcb_sys_tb.sv
//////////////////////////////
// table-driven testbench for tcb_sys
// commands driven on falling edges, outputs sampled on rising
// expected words are hand-merged, memory is read only after a write
// hold field delays the response credit of an entry
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "tcb_macros.svh"

module tcb_sys_tb;

  localparam int CRD   = `TCB_CRD;
  localparam int LIMIT = 200;
  localparam tcb_pkg::tcb_op_e RD = tcb_pkg::OP_RD;
  localparam tcb_pkg::tcb_op_e WR = tcb_pkg::OP_WR;

  // one table row, stimulus then expected response
  typedef struct packed {
    tcb_pkg::tcb_op_e   op;
    logic [`TCB_AW-1:0] adr;
    logic [`TCB_BW-1:0] ben;
    logic [`TCB_DW-1:0] wdt;
    logic [`TCB_DW-1:0] rdt;
    logic               err;
    logic [7:0]         hold;
  } entry_t;

  logic              bus = 1'b0;
  logic              reset;
  logic              cmd_vld;
  tcb_pkg::tcb_cmd_t cmd;
  logic              cmd_crd;
  logic              rsp_vld;
  tcb_pkg::tcb_rsp_t rsp;
  logic              rsp_crd;

  entry_t tbl[$];
  // table indices awaiting a response, oldest first
  int     exp_q[$];
  entry_t e;
  int     sent = 0;
  int     crd_pulses = 0;
  int     crd_returned = 0;
  int     rsp_cnt = 0;

  // 40 ns period
  always #20 bus = ~bus;

  tcb_sys i_tcb_sys (
    .bus     (bus),
    .reset   (reset),
    .cmd_vld (cmd_vld),
    .cmd     (cmd),
    .cmd_crd (cmd_crd),
    .rsp_vld (rsp_vld),
    .rsp     (rsp),
    .rsp_crd (rsp_crd)
  );

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    if (act !== exp) begin
      stop_on_failure($sformatf("** Error: %s is 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic add_entry(input tcb_pkg::tcb_op_e op, input logic [15:0] adr,
                           input logic [3:0] ben, input logic [31:0] wdt,
                           input logic [31:0] rdt, input logic err, input logic [7:0] hold);
    tbl.push_back('{op, adr, ben, wdt, rdt, err, hold});
  endtask

  task automatic load_table();
    // register bank, zero after reset, then writes
    add_entry(RD, 16'h8000, 4'hf, 32'h0, 32'h0, 1'b0, 8'd0);
    add_entry(RD, 16'h801c, 4'hf, 32'h0, 32'h0, 1'b0, 8'd0);
    add_entry(WR, 16'h8004, 4'hf, 32'hdead_beef, 32'h0, 1'b0, 8'd0);
    add_entry(RD, 16'h8004, 4'hf, 32'h0, 32'hdead_beef, 1'b0, 8'd2);
    add_entry(WR, 16'h8004, 4'h3, 32'h0000_1234, 32'h0, 1'b0, 8'd0);
    add_entry(RD, 16'h8004, 4'hf, 32'h0, 32'hdead_1234, 1'b0, 8'd0);
    // past 0x1c, then misaligned write that must not land
    add_entry(RD, 16'h8020, 4'hf, 32'h0, 32'h0, 1'b1, 8'd0);
    add_entry(WR, 16'h8006, 4'hf, 32'hffff_ffff, 32'h0, 1'b1, 8'd0);
    add_entry(RD, 16'h8004, 4'hf, 32'h0, 32'hdead_1234, 1'b0, 8'd0);
    // memory byte merges
    add_entry(WR, 16'h0010, 4'hf, 32'h1122_3344, 32'h0, 1'b0, 8'd0);
    add_entry(WR, 16'h0010, 4'ha, 32'haabb_ccdd, 32'h0, 1'b0, 8'd0);
    add_entry(RD, 16'h0010, 4'hf, 32'h0, 32'haa22_cc44, 1'b0, 8'd3);
    add_entry(WR, 16'h0010, 4'h1, 32'h0000_00ee, 32'h0, 1'b0, 8'd0);
    add_entry(RD, 16'h0010, 4'hf, 32'h0, 32'haa22_ccee, 1'b0, 8'd0);
    // unmapped memory, aliases word 4
    add_entry(WR, 16'h0410, 4'hf, 32'h5555_5555, 32'h0, 1'b1, 8'd0);
    add_entry(RD, 16'h7c10, 4'hf, 32'h0, 32'h0, 1'b1, 8'd0);
    add_entry(RD, 16'h0010, 4'hf, 32'h0, 32'haa22_ccee, 1'b0, 8'd0);
    // alternating sides back to back
    add_entry(WR, 16'h0020, 4'hf, 32'h0a0a_0a0a, 32'h0, 1'b0, 8'd0);
    add_entry(WR, 16'h8008, 4'hf, 32'h0b0b_0b0b, 32'h0, 1'b0, 8'd0);
    add_entry(RD, 16'h0020, 4'hf, 32'h0, 32'h0a0a_0a0a, 1'b0, 8'd0);
    add_entry(RD, 16'h8008, 4'hf, 32'h0, 32'h0b0b_0b0b, 1'b0, 8'd0);
    add_entry(RD, 16'h0010, 4'hf, 32'h0, 32'haa22_ccee, 1'b0, 8'd0);
    add_entry(RD, 16'h8004, 4'hf, 32'h0, 32'hdead_1234, 1'b0, 8'd0);
    // credit withheld long enough to stall the manager
    add_entry(RD, 16'h0020, 4'hf, 32'h0, 32'h0a0a_0a0a, 1'b0, 8'd40);
    add_entry(RD, 16'h8008, 4'hf, 32'h0, 32'h0b0b_0b0b, 1'b0, 8'd0);
    add_entry(RD, 16'h0010, 4'hf, 32'h0, 32'haa22_ccee, 1'b0, 8'd0);
    add_entry(RD, 16'h8000, 4'hf, 32'h0, 32'h0, 1'b0, 8'd0);
    add_entry(RD, 16'h0020, 4'hf, 32'h0, 32'h0a0a_0a0a, 1'b0, 8'd0);
    add_entry(RD, 16'h8004, 4'hf, 32'h0, 32'hdead_1234, 1'b0, 8'd0);
    add_entry(WR, 16'h8018, 4'hf, 32'h1234_5678, 32'h0, 1'b0, 8'd0);
    add_entry(RD, 16'h8018, 4'hf, 32'h0, 32'h1234_5678, 1'b0, 8'd0);
  endtask

  // one command per falling edge while credit lasts
  task automatic send_commands();
    int t;
    for (int i = 0; i < tbl.size(); i++) begin
      t = 0;
      while (CRD - sent + crd_pulses <= 0) begin
        cmd_vld = 1'b0;
        @(negedge bus);
        t++;
        if (t > LIMIT) stop_on_failure($sformatf("timeout: no command credit for entry %0d", i));
      end
      cmd_vld = 1'b1;
      cmd.op  = tbl[i].op;
      cmd.adr = tbl[i].adr;
      cmd.ben = tbl[i].ben;
      cmd.wdt = tbl[i].wdt;
      exp_q.push_back(i);
      sent++;
      @(negedge bus);
    end
    cmd_vld = 1'b0;
  endtask

  // one rsp_crd cycle per response, after its hold
  task automatic return_credits();
    int t;
    for (int j = 0; j < tbl.size(); j++) begin
      t = 0;
      while (rsp_cnt <= j) begin
        @(negedge bus);
        t++;
        if (t > LIMIT) stop_on_failure($sformatf("timeout: no response for entry %0d", j));
      end
      repeat (tbl[j].hold) @(negedge bus);
      rsp_crd = 1'b1;
      @(negedge bus);
      rsp_crd = 1'b0;
    end
  endtask

  //////////////////////////////
  // response and credit monitor
  //////////////////////////////
  always @(posedge bus) begin
    if (!reset) begin
      if (cmd_crd) crd_pulses++;
      if (rsp_crd) crd_returned++;
      if (rsp_vld) begin
        if (exp_q.size() == 0) stop_on_failure("rsp_vld with no command outstanding");
        e = tbl[exp_q.pop_front()];
        check_value("rsp.rdt", rsp.rdt, e.rdt);
        check_value("rsp.err", 32'(rsp.err), 32'(e.err));
        rsp_cnt++;
        check_value("rsp_vld within credits", 32'(rsp_cnt <= CRD + crd_returned), 1);
      end
      // issues may not outrun returned credits
      check_value("cmd_crd within credits", 32'(crd_pulses <= CRD + crd_returned), 1);
    end
  end

  initial begin
    cmd_vld = 1'b0;
    cmd     = '0;
    rsp_crd = 1'b0;
    reset   = 1'b1;
    load_table();
    repeat (2) @(negedge bus);
    reset = 1'b0;
    fork
      send_commands();
      return_credits();
    join
    check_value("cmd_crd pulse count", crd_pulses, tbl.size());
    check_value("responses received", rsp_cnt, tbl.size());
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- tcb_sys.f
+incdir+rtl
rtl/tcb_pkg.sv
rtl/tcb_man.sv
rtl/tcb_dec.sv
rtl/tcb_mem.sv
rtl/tcb_reg.sv
rtl/tcb_sys.sv
verif/tcb_sys_props.sv
verif/tcb_sys_tb.sv

//--- Makefile
# Verilator build and run for the TCB subsystem

VERILATOR ?= verilator
TOP       ?= tcb_sys_tb
FLIST     ?= tcb_sys.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
EXE     := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: compile
	-./$(EXE) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || { echo "FAIL"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
